// File: ipcpPkg.sv
`default_nettype none

package ipcpPkg;

    localparam int AddrWidth = 32;
    localparam int LineLsb = 5;                     // 32-byte lines
    localparam int LineWidth = AddrWidth - LineLsb;
    localparam int StrideWidth = 8;                 // Signed, in lines
    localparam int SigWidth = 7;

    localparam int ClassWidth = 2;
    localparam logic [ClassWidth-1:0] ClassNl = 2'd0;
    localparam logic [ClassWidth-1:0] ClassCs = 2'd1;
    localparam logic [ClassWidth-1:0] ClassCplx = 2'd2;
    localparam logic [ClassWidth-1:0] ClassGs = 2'd3;

    // Table geometry
    localparam int IpIndexWidth = 6;
    localparam int IpEntryWidth = 32;
    localparam int RegionIndexWidth = 4;
    localparam int RegionEntryWidth = 66;
    localparam int CsptIndexWidth = 7;
    localparam int CsptDataWidth = StrideWidth + 2; // Stride and 2-bit confidence

    // Lines per burst
    localparam int DegreeCs = 3;
    localparam int DegreeGs = 4;
    localparam int DegreeCplx = 1;
    localparam int DegreeWidth = $clog2(DegreeGs + 1);

    localparam int FilterDepth = 4;

endpackage

`default_nettype wire

// File: bram.sv
`default_nettype none

module bram
#(
    parameter int DataWidth = 32,
    parameter int AddrWidth = 6
)
(
    input  logic                 clk,
    input  logic                 we,
    input  logic [AddrWidth-1:0] waddr,
    input  logic [AddrWidth-1:0] raddr,
    input  logic [DataWidth-1:0] din,
    output logic [DataWidth-1:0] dout
);

    logic [DataWidth-1:0] mem [2**AddrWidth];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= din;
        dout <= mem[raddr];   // Old data on a same-address write
    end

endmodule

`default_nettype wire

// File: classifyIf.sv
`default_nettype none

interface classifyIf import ipcpPkg::*;
();

    logic                   valid;      // One-cycle strobe, never with ClassNl
    logic [LineWidth-1:0]   lineBase;
    logic [StrideWidth-1:0] stride;
    logic [ClassWidth-1:0]  classCode;
    logic [SigWidth-1:0]    ipSig;

    modport producer
    (
        output valid,
        output lineBase,
        output stride,
        output classCode,
        output ipSig
    );

    modport consumer
    (
        input valid,
        input lineBase,
        input stride,
        input classCode,
        input ipSig
    );

endinterface

`default_nettype wire

// File: accessFilter.sv
`default_nettype none

module accessFilter import ipcpPkg::*;
(
    input  logic                 clk,
    input  logic                 RST_vout,
    input  logic [AddrWidth-1:0] ip,
    input  logic [AddrWidth-1:0] addr,
    input  logic                 valid,
    output logic [AddrWidth-1:0] fIp,
    output logic [AddrWidth-1:0] fAddr,
    output logic                 fValid
);

    logic [LineWidth-1:0] histLine [FilterDepth];
    logic [FilterDepth-1:0] histValid;
    logic [$clog2(FilterDepth)-1:0] victim;
    logic [LineWidth-1:0] line;
    logic hit;
    logic accept;

    assign line = addr[AddrWidth-1:LineLsb];

    // Compare against every remembered line
    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < FilterDepth; i++)
        begin
            if (histValid[i] && histLine[i] == line)
                hit = 1'b1;
        end
    end

    assign accept = valid && !hit;

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            histValid <= '0;
            victim <= '0;
            fValid <= 1'b0;
        end
        else
        begin
            fValid <= accept;
            if (accept)
            begin
                histValid[victim] <= 1'b1;
                victim <= victim + 1'b1;   // Round robin
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            histLine[victim] <= line;
            fIp <= ip;
            fAddr <= addr;
        end
    end

endmodule

`default_nettype wire

// File: ipcpLaunch.sv
`default_nettype none

module ipcpLaunch import ipcpPkg::*;
(
    input  logic                      clk,
    input  logic                      RST_vout,
    input  logic [AddrWidth-1:0]      ip,
    input  logic [AddrWidth-1:0]      addr,
    input  logic                      valid,
    input  logic [CsptIndexWidth-1:0] csptLookAddr,
    output logic [CsptDataWidth-1:0]  csptData,
    classifyIf.producer               cls
);

    logic valid0, valid1, nValid1;
    logic [LineWidth-1:0] line0, line1;
    logic [IpIndexWidth-1:0] ipIdx0, ipIdx1;
    logic [8:0] ipTag0;
    logic [ClassWidth-1:0] type0, type1, type2;
    logic [StrideWidth-1:0] rawStride, stride0, stride1, stride2;
    logic [8:0] lineDelta;

    logic [IpEntryWidth-1:0] ipDout, ipFwdData, ipEntry, ipDin;
    logic ipFwd;
    logic [8:0] ipTag, ipTagNew;
    logic ipV, ipVNew, ipSv, ipSvNew, ipTe, ipTeNew, ipDr, ipDrNew;
    logic [1:0] ipLvp, ipLvpNew, ipConf, ipConfNew;
    logic [6:0] ipOff, ipOffNew;
    logic [StrideWidth-1:0] ipStr, ipStrNew;

    logic [SigWidth-1:0] sigDout, sigFwdData, sigRead, sigCur, sig1, sigNext;
    logic sigFwd, sigWe;

    logic [RegionEntryWidth-1:0] rgDout, rgFwdData, rgEntry, rgDin;
    logic rgFwd, rgHit;
    logic [9:0] rgTag, rgTagNew;
    logic [5:0] regionConf, regionConfNew, rgPnc, rgPncNew;
    logic [4:0] rgOff, rgOffNew, rgDe, rgDeNew;
    logic [31:0] rgBv, rgBvNew, lineBit;
    logic rgTr, rgTrNew, rgDr, rgDrNew;

    logic [CsptDataWidth-1:0] csptDout, csptFwdData, csptEntry, csptDin;
    logic [CsptIndexWidth-1:0] csptWaddr;
    logic csptFwd, csptWe;
    logic [StrideWidth-1:0] csptStr, csptStrNew;
    logic [1:0] csptConf, csptConfNew;

    bram #(.DataWidth(IpEntryWidth), .AddrWidth(IpIndexWidth)) ipTable
    (
        .clk(clk), .we(valid0), .waddr(ipIdx0), .raddr(ip[7:2]), .din(ipDin), .dout(ipDout)
    );

    bram #(.DataWidth(SigWidth), .AddrWidth(IpIndexWidth)) sigTable
    (
        .clk(clk), .we(sigWe), .waddr(ipIdx1), .raddr(ip[7:2]), .din(sigNext), .dout(sigDout)
    );

    bram #(.DataWidth(RegionEntryWidth), .AddrWidth(RegionIndexWidth)) regionTable
    (
        .clk(clk), .we(valid0), .waddr(line0[8:5]), .raddr(addr[13:10]),
        .din(rgDin), .dout(rgDout)
    );

    bram #(.DataWidth(CsptDataWidth), .AddrWidth(CsptIndexWidth)) csptTable
    (
        .clk(clk), .we(csptWe), .waddr(csptWaddr), .raddr(sigCur), .din(csptDin), .dout(csptDout)
    );

    // Shadow copy for the external lookup port
    bram #(.DataWidth(CsptDataWidth), .AddrWidth(CsptIndexWidth)) csptShadow
    (
        .clk(clk), .we(csptWe), .waddr(csptWaddr), .raddr(csptLookAddr),
        .din(csptDin), .dout(csptData)
    );

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            valid0 <= 1'b0;
            valid1 <= 1'b0;
            ipFwd <= 1'b0;
            rgFwd <= 1'b0;
            sigFwd <= 1'b0;
            csptFwd <= 1'b0;
        end
        else
        begin
            valid0 <= valid;
            valid1 <= nValid1;
            ipFwd <= valid0 && ipIdx0 == ip[7:2];   // Write and read at the same edge
            rgFwd <= valid0 && line0[8:5] == addr[13:10];
            sigFwd <= sigWe && ipIdx1 == ip[7:2];
            csptFwd <= csptWe && csptWaddr == sigCur;
        end
    end

    always_ff @(posedge clk)
    begin
        line0 <= addr[AddrWidth-1:LineLsb];
        line1 <= line0;
        ipIdx0 <= ip[7:2];
        ipTag0 <= ip[16:8];
        ipIdx1 <= ipIdx0;
        type1 <= type0;
        stride1 <= stride0;
        sig1 <= sigCur;
        csptWaddr <= sigCur;
        ipFwdData <= ipDin;
        rgFwdData <= rgDin;
        sigFwdData <= sigNext;
        csptFwdData <= csptDin;
    end

    assign ipEntry = ipFwd ? ipFwdData : ipDout;
    assign rgEntry = rgFwd ? rgFwdData : rgDout;
    assign csptEntry = csptFwd ? csptFwdData : csptDout;
    assign sigRead = sigFwd ? sigFwdData : sigDout;
    assign sigCur = (sigWe && ipIdx1 == ipIdx0) ? sigNext : sigRead;   // Same IP in stage 1

    assign {ipTag, ipV, ipLvp, ipOff, ipStr, ipConf, ipSv, ipTe, ipDr} = ipEntry;
    assign ipDin = {ipTagNew, ipVNew, ipLvpNew, ipOffNew, ipStrNew, ipConfNew,
                    ipSvNew, ipTeNew, ipDrNew};
    assign {rgTag, regionConf, rgOff, rgBv, rgPnc, rgDe, rgTr, rgDr} = rgEntry;
    assign rgDin = {rgTagNew, regionConfNew, rgOffNew, rgBvNew, rgPncNew, rgDeNew,
                    rgTrNew, rgDrNew};
    assign {csptStr, csptConf} = csptEntry;
    assign csptDin = {csptStrNew, csptConfNew};

    assign lineDelta = line0[8:0] - {ipLvp, ipOff};
    assign rawStride = lineDelta[StrideWidth-1:0];
    assign rgHit = rgTag == line0[18:9];
    assign lineBit = 32'b1 << line0[4:0];

    // Stage 0, IP table
    always_comb
    begin
        {ipTagNew, ipVNew, ipLvpNew, ipOffNew, ipStrNew, ipConfNew} =
            {ipTag, ipV, ipLvp, ipOff, ipStr, ipConf};
        {ipSvNew, ipTeNew, ipDrNew} = {ipSv, ipTe, ipDr};
        type0 = ClassNl;
        stride0 = rawStride;
        nValid1 = valid0;
        if (ipTag != ipTag0)
        begin
            nValid1 = 1'b0;
            ipVNew = 1'b0;   // Decay first, replace on the next miss
            if (!ipV)
            begin
                ipTagNew = ipTag0;
                ipLvpNew = line0[8:7];
                ipOffNew = line0[6:0];
                {ipStrNew, ipConfNew, ipSvNew, ipTeNew, ipDrNew} = '0;
            end
        end
        else
        begin
            ipVNew = 1'b1;
            ipLvpNew = line0[8:7];
            ipOffNew = line0[6:0];
            if (rgHit)
                ipTeNew = ~rgTr;
            if (rgHit && rgTr)
            begin
                ipSvNew = 1'b1;
                ipDrNew = rgDr;
            end
            else if (ipTe && line0[8:7] != ipLvp)
                ipSvNew = 1'b0;   // Stream left its page
            if (ipSv)
            begin
                type0 = ClassGs;
                stride0 = {{(StrideWidth-1){ipDr}}, 1'b1};
            end
            else
            begin
                if (rawStride != ipStr && ipConf != 2'b00)
                    ipConfNew = ipConf - 1'b1;
                if (rawStride == ipStr && ipConf != 2'b11)
                    ipConfNew = ipConf + 1'b1;
                if (ipConf == 2'b00)
                    ipStrNew = rawStride;
                if (ipConf[1])
                begin
                    type0 = ClassCs;
                    stride0 = ipStr;
                end
                else
                    type0 = ClassCplx;
            end
            if (stride0 == '0)
            begin
                type0 = ClassNl;
                nValid1 = 1'b0;
            end
        end
    end

    // Stage 0, region stream table
    always_comb
    begin
        {rgTagNew, regionConfNew, rgOffNew, rgBvNew} = {rgTag, regionConf, rgOff, rgBv};
        {rgPncNew, rgDeNew, rgTrNew, rgDrNew} = {rgPnc, rgDe, rgTr, rgDr};
        if (!rgHit)
        begin
            if (regionConf == '0)
            begin
                rgTagNew = line0[18:9];
                rgOffNew = line0[4:0];
                rgBvNew = '0;
                rgPncNew = 6'b100000;   // Midpoint of the direction counter
                rgDeNew = '0;
                rgTrNew = 1'b0;
                rgDrNew = 1'b1;
            end
            else
                regionConfNew = regionConf - 1'b1;
        end
        else
        begin
            if (regionConf != 6'h3f)
                regionConfNew = regionConf + 1'b1;
            rgOffNew = line0[4:0];
            rgBvNew = rgBv | lineBit;
            if (rgPnc != '0 && line0[4:0] < rgOff)
                rgPncNew = rgPnc - 1'b1;
            else if (rgPnc != 6'h3f && line0[4:0] > rgOff)
                rgPncNew = rgPnc + 1'b1;
            if ((rgBv & lineBit) == '0)
                rgDeNew = rgDe + 1'b1;   // New line in region
            rgTrNew = rgTr | (&rgDe[4:3]);
            rgDrNew = ~rgPncNew[5];
        end
    end

    // Stage 1, pattern table
    always_comb
    begin
        type2 = type1;
        stride2 = stride1;
        csptWe = 1'b0;
        sigWe = 1'b0;
        csptStrNew = csptStr;
        csptConfNew = csptConf;
        if (valid1 && type1 == ClassCplx)
        begin
            csptWe = 1'b1;
            sigWe = 1'b1;
            if (!csptConf[1])
                type2 = ClassNl;
            if (csptConf == 2'b00)
                csptStrNew = stride1;
            else
                stride2 = csptStr;
            if (stride1 == csptStr && csptConf != 2'b11)
                csptConfNew = csptConf + 1'b1;
            else if (stride1 != csptStr && csptConf != 2'b00)
                csptConfNew = csptConf - 1'b1;
        end
    end

    assign sigNext = {sig1[SigWidth-2:0], 1'b0} ^ stride1[SigWidth-1:0];

    assign cls.valid = valid1 && type2 != ClassNl;
    assign cls.lineBase = line1;
    assign cls.stride = stride2;
    assign cls.classCode = type2;
    assign cls.ipSig = sigNext;

endmodule

`default_nettype wire

// File: prefetchIssue.sv
`default_nettype none

module prefetchIssue import ipcpPkg::*;
(
    input  logic                  clk,
    input  logic                  RST_vout,
    classifyIf.consumer           cls,
    output logic [LineWidth-1:0]  prefetchAddr,
    output logic                  prefetchValid,
    output logic [ClassWidth-1:0] prefetchClass
);

    logic [LineWidth-1:0] strideExt;
    logic [LineWidth-1:0] step;
    logic [DegreeWidth-1:0] degree;
    logic [DegreeWidth-1:0] remaining;

    assign strideExt = {{(LineWidth - StrideWidth){cls.stride[StrideWidth-1]}}, cls.stride};

    // Burst length per class
    always_comb
    begin
        case (cls.classCode)
            ClassCs: degree = DegreeWidth'(DegreeCs);
            ClassGs: degree = DegreeWidth'(DegreeGs);
            default: degree = DegreeWidth'(DegreeCplx);
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            prefetchValid <= 1'b0;
            remaining <= '0;
        end
        else if (cls.valid)
        begin
            prefetchValid <= 1'b1;   // New job replaces a running burst
            remaining <= degree - 1'b1;
        end
        else if (remaining != '0)
        begin
            prefetchValid <= 1'b1;
            remaining <= remaining - 1'b1;
        end
        else
            prefetchValid <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (cls.valid)
        begin
            prefetchAddr <= cls.lineBase + strideExt;   // First line past the access
            step <= strideExt;
            prefetchClass <= cls.classCode;
        end
        else if (remaining != '0)
            prefetchAddr <= prefetchAddr + step;
    end

endmodule

`default_nettype wire

// File: ipcpPrefetcher.sv
`default_nettype none

module ipcpPrefetcher import ipcpPkg::*;
(
    input  logic                      clk,
    input  logic                      RST_vout,
    input  logic [AddrWidth-1:0]      accIp,
    input  logic [AddrWidth-1:0]      accAddr,
    input  logic                      accValid,
    input  logic [CsptIndexWidth-1:0] csptLookAddr,
    output logic [CsptDataWidth-1:0]  csptData,
    output logic [LineWidth-1:0]      prefetchAddr,
    output logic                      prefetchValid,
    output logic [ClassWidth-1:0]     prefetchClass
);

    logic [AddrWidth-1:0] fIp;
    logic [AddrWidth-1:0] fAddr;
    logic fValid;

    classifyIf clsBus ();

    accessFilter uFilter
    (
        .clk(clk),
        .RST_vout(RST_vout),
        .ip(accIp),
        .addr(accAddr),
        .valid(accValid),
        .fIp(fIp),
        .fAddr(fAddr),
        .fValid(fValid)
    );

    ipcpLaunch uLaunch
    (
        .clk(clk),
        .RST_vout(RST_vout),
        .ip(fIp),
        .addr(fAddr),
        .valid(fValid),
        .csptLookAddr(csptLookAddr),
        .csptData(csptData),
        .cls(clsBus.producer)
    );

    prefetchIssue uIssue
    (
        .clk(clk),
        .RST_vout(RST_vout),
        .cls(clsBus.consumer),
        .prefetchAddr(prefetchAddr),
        .prefetchValid(prefetchValid),
        .prefetchClass(prefetchClass)
    );

endmodule

`default_nettype wire

// File: tbIpcp_sva.sv
`default_nettype none

module tbIpcpSva import ipcpPkg::*;
(
    input logic                      clk,
    input logic                      RST_vout,
    input logic [AddrWidth-1:0]      accIp,
    input logic [AddrWidth-1:0]      accAddr,
    input logic                      accValid,
    input logic [CsptIndexWidth-1:0] csptLookAddr,
    input logic [CsptDataWidth-1:0]  csptData,
    input logic [LineWidth-1:0]      prefetchAddr,
    input logic                      prefetchValid,
    input logic [ClassWidth-1:0]     prefetchClass,
    input logic                      fValid,
    input logic [AddrWidth-1:0]      fAddr,
    input logic                      csptWe,
    input logic [CsptIndexWidth-1:0] csptWaddr
);

    logic [LineWidth-1:0] histLine [FilterDepth];
    logic [FilterDepth-1:0] histValid;
    logic [$clog2(FilterDepth)-1:0] victim;
    logic [LineWidth-1:0] line, delta, lastLine, lastDelta;
    logic [AddrWidth-1:0] lastIp, addrQ;
    logic lastValid, deltaValid, hit, accept, sameIp, confirmed;
    logic [1:0] confRun;                    // Confirmed steps in a row, saturating
    logic [7:1] accHist;                    // Bit k is an accept k cycles back
    logic [5:1] confHist;
    logic [4:1] csDue;
    logic [LineWidth-1:0] lineHist [1:5];
    logic [LineWidth-1:0] deltaHist [1:5];
    logic [LineWidth-1:0] prevAddr, prevStep, curStep, gsExpect;
    logic [LineWidth-1:0] secondStep, secondExpect;
    logic prevValid, prev2Valid;
    logic [2**CsptIndexWidth-1:0] written;
    logic lookWritten;
    logic failReset = 1'b0;
    logic failFilter = 1'b0;
    logic failOrigin = 1'b0;
    logic failClass = 1'b0;
    logic failStep = 1'b0;
    logic failCsFirst = 1'b0;
    logic failCsRun = 1'b0;
    logic failSecond = 1'b0;
    logic failGsFirst = 1'b0;
    logic failGsStep = 1'b0;
    logic failCspt = 1'b0;
    logic failed;

    assign line = accAddr[AddrWidth-1:LineLsb];
    assign delta = line - lastLine;
    assign sameIp = lastValid && accIp == lastIp;
    // Two equal small line steps in a row from one IP
    assign confirmed = sameIp && deltaValid && delta == lastDelta && delta != '0
        && (&delta[LineWidth-1:StrideWidth-1] || ~|delta[LineWidth-1:StrideWidth-1]);
    assign accept = accValid && !hit;
    assign curStep = prefetchAddr - prevAddr;
    assign gsExpect = lineHist[4] + (deltaHist[4][LineWidth-1] ? {LineWidth{1'b1}}
                                                              : LineWidth'(1));
    assign secondStep = prefetchClass == ClassGs
        ? (deltaHist[5][LineWidth-1] ? {LineWidth{1'b1}} : LineWidth'(1))
        : deltaHist[5];
    assign secondExpect = lineHist[5] + (secondStep << 1);
    assign failed = failReset | failFilter | failOrigin | failClass | failStep
                    | failCsFirst | failCsRun | failSecond | failGsFirst | failGsStep
                    | failCspt;

    always_comb
    begin
        hit = 1'b0;
        for (int i = 0; i < FilterDepth; i++)
        begin
            if (histValid[i] && histLine[i] == line)
                hit = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            histValid <= '0;
            victim <= '0;
            lastValid <= 1'b0;
            deltaValid <= 1'b0;
            confRun <= '0;
            accHist <= '0;
            prevValid <= 1'b0;
            prev2Valid <= 1'b0;
            written <= '0;
        end
        else
        begin
            accHist <= {accHist[6:1], accept};
            prevValid <= prefetchValid;
            prev2Valid <= prevValid;
            if (csptWe)
                written[csptWaddr] <= 1'b1;
            if (accept)
            begin
                histValid[victim] <= 1'b1;
                victim <= victim + 1'b1;
                lastValid <= 1'b1;
                deltaValid <= sameIp;
                if (!confirmed)
                    confRun <= '0;
                else if (confRun != 2'd3)
                    confRun <= confRun + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        lineHist[1] <= line;
        deltaHist[1] <= delta;
        for (int k = 2; k <= 5; k++)
        begin
            lineHist[k] <= lineHist[k-1];
            deltaHist[k] <= deltaHist[k-1];
        end
        confHist <= {confHist[4:1], accept && confirmed};
        csDue <= {csDue[3:1], accept && confirmed && confRun[1]};   // Two matches before
        addrQ <= accAddr;
        prevAddr <= prefetchAddr;
        prevStep <= curStep;
        lookWritten <= written[csptLookAddr];   // Shadow read sees the old contents
        if (accept)
        begin
            histLine[victim] <= line;
            lastIp <= accIp;
            lastLine <= line;
            lastDelta <= delta;
        end
    end

    assert property (@(posedge clk) !RST_vout |=> !prefetchValid && !fValid)
    else
    begin
        failReset = 1'b1;
        $error("FAIL prefetchValid got %h fValid got %h expected 0",
               $sampled(prefetchValid), $sampled(fValid));
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        fValid == accHist[1] && (!fValid || fAddr == addrQ))
    else
    begin
        failFilter = 1'b1;
        $error("FAIL fValid got %h expected %h, fAddr got %h expected %h",
               $sampled(fValid), $sampled(accHist[1]), $sampled(fAddr), $sampled(addrQ));
    end

    // A burst lives at most DegreeGs cycles past its access
    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid |-> |accHist[7:4])
    else
    begin
        failOrigin = 1'b1;
        $error("Prefetch issued with no accepted access 4 to 7 cycles earlier");
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid |-> prefetchClass != ClassNl)
    else
    begin
        failClass = 1'b1;
        $error("FAIL prefetchClass got %h during a prefetch", $sampled(prefetchClass));
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid && prevValid && prev2Valid && !accHist[4] && !accHist[5]
        |-> curStep == prevStep)
    else
    begin
        failStep = 1'b1;
        $error("FAIL prefetchAddr step got %h expected %h",
               $sampled(curStep), $sampled(prevStep));
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid && confHist[4] && prefetchClass == ClassCs
        |-> prefetchAddr == lineHist[4] + deltaHist[4])
    else
    begin
        failCsFirst = 1'b1;
        $error("FAIL prefetchAddr got %h expected %h",
               $sampled(prefetchAddr), $sampled(lineHist[4] + deltaHist[4]));
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        csDue[4] |-> prefetchValid && (prefetchClass == ClassCs || prefetchClass == ClassGs))
    else
    begin
        failCsRun = 1'b1;
        $error("No stride or stream prefetch 4 cycles after a confirmed stride run");
    end

    // Second line of a stride or stream burst
    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid && confHist[5] && !accHist[4]
        && (prefetchClass == ClassCs || prefetchClass == ClassGs)
        |-> prefetchAddr == secondExpect)
    else
    begin
        failSecond = 1'b1;
        $error("FAIL prefetchAddr got %h expected %h",
               $sampled(prefetchAddr), $sampled(secondExpect));
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid && confHist[4] && prefetchClass == ClassGs
        |-> prefetchAddr == gsExpect)
    else
    begin
        failGsFirst = 1'b1;
        $error("FAIL prefetchAddr got %h expected %h",
               $sampled(prefetchAddr), $sampled(gsExpect));
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        prefetchValid && prevValid && !accHist[4] && prefetchClass == ClassGs
        |-> curStep == LineWidth'(1) || curStep == {LineWidth{1'b1}})
    else
    begin
        failGsStep = 1'b1;
        $error("FAIL prefetchAddr step got %h expected 1 or %h",
               $sampled(curStep), {LineWidth{1'b1}});
    end

    assert property (@(posedge clk) disable iff (!RST_vout)
        lookWritten |-> !$isunknown(csptData))
    else
    begin
        failCspt = 1'b1;
        $error("Pattern table lookup returned unknown bits from a written entry");
    end

endmodule

`default_nettype wire

// File: tbIpcp.sv
`default_nettype none

module tbIpcp import ipcpPkg::*;
();

    localparam int ResetCycles = 4;
    localparam int Drain = 12;
    localparam int RandomCount = 400;
    localparam int StimCycles = ResetCycles + 8 + (8 + Drain) + (12 * 4 + Drain)
                                + 2 * (32 * 4 + Drain) + (RandomCount + Drain);
    localparam int CycleLimit = StimCycles + 64;

    logic clk;
    logic RST_vout;
    logic [AddrWidth-1:0] accIp;
    logic [AddrWidth-1:0] accAddr;
    logic accValid;
    logic [CsptIndexWidth-1:0] csptLookAddr;
    logic [CsptDataWidth-1:0] csptData;
    logic [LineWidth-1:0] prefetchAddr;
    logic prefetchValid;
    logic [ClassWidth-1:0] prefetchClass;
    int cycleCount = 0;

    ipcpPrefetcher UUT
    (
        .clk(clk),
        .RST_vout(RST_vout),
        .accIp(accIp),
        .accAddr(accAddr),
        .accValid(accValid),
        .csptLookAddr(csptLookAddr),
        .csptData(csptData),
        .prefetchAddr(prefetchAddr),
        .prefetchValid(prefetchValid),
        .prefetchClass(prefetchClass)
    );

    bind ipcpPrefetcher tbIpcpSva checks
    (
        .clk(clk),
        .RST_vout(RST_vout),
        .accIp(accIp),
        .accAddr(accAddr),
        .accValid(accValid),
        .csptLookAddr(csptLookAddr),
        .csptData(csptData),
        .prefetchAddr(prefetchAddr),
        .prefetchValid(prefetchValid),
        .prefetchClass(prefetchClass),
        .fValid(fValid),
        .fAddr(fAddr),
        .csptWe(uLaunch.csptWe),
        .csptWaddr(uLaunch.csptWaddr)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("test failed");
            $fatal(1, "Timeout after %0d cycles", cycleCount);
        end
    end

    always @(negedge clk)
    begin
        if (UUT.checks.failed)
        begin
            $display("test failed");
            $fatal(1, "Stopped at the first assertion failure");
        end
    end

    // One access, then gap-1 idle cycles
    task automatic driveAccess(input logic [AddrWidth-1:0] ip,
                               input logic [AddrWidth-1:0] addr, input int gap);
        @(posedge clk);
        accIp <= ip;
        accAddr <= addr;
        accValid <= 1'b1;
        csptLookAddr <= CsptIndexWidth'($urandom);
        repeat (gap - 1)
        begin
            @(posedge clk);
            accValid <= 1'b0;
            csptLookAddr <= CsptIndexWidth'($urandom);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            accValid <= 1'b0;
        end
    endtask

    initial
    begin
        logic [AddrWidth-1:0] rIp;
        logic [AddrWidth-1:0] rAddr;
        void'($urandom(1464));
        clk = 1'b0;
        RST_vout = 1'b0;
        accIp = '0;
        accAddr = '0;
        accValid = 1'b0;
        csptLookAddr = '0;
        rIp = 32'h0000_5514;
        rAddr = 32'h0100_0000;
        repeat (ResetCycles) @(posedge clk);
        RST_vout <= 1'b1;
        idleCycles(8);
        for (int i = 0; i < 8; i++)
            driveAccess(32'h0000_4410, 32'h0080_0000, 1);   // Same line back to back
        idleCycles(Drain);
        for (int i = 0; i < 12; i++)
            driveAccess(32'h0000_1104, 32'h0010_0000 + i * 64, 4);
        idleCycles(Drain);
        // Dense sweeps over two fresh regions, up then down
        for (int i = 0; i < 32; i++)
            driveAccess(32'h0000_2208, 32'h0020_0400 + i * 32, 4);
        idleCycles(Drain);
        for (int i = 0; i < 32; i++)
            driveAccess(32'h0000_330C, 32'h0060_0800 + (31 - i) * 32, 4);
        idleCycles(Drain);
        for (int i = 0; i < RandomCount; i++)
        begin
            if ($urandom % 4 != 0)
            begin
                rIp = $urandom;
                rAddr = $urandom;
            end
            driveAccess(rIp, rAddr, 1);
        end
        idleCycles(Drain);
        if (UUT.checks.failed)
        begin
            $display("test failed");
            $fatal(1, "Assertion failure seen at the end of the run");
        end
        else
        begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: all.f
ipcpPkg.sv
bram.sv
classifyIf.sv
accessFilter.sv
ipcpLaunch.sv
prefetchIssue.sv
ipcpPrefetcher.sv
tbIpcp_sva.sv
tbIpcp.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tbIpcp
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
SIMARGS ?= +verilator+error+limit+1000
PASS_MSG = test passed
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
